/* Bender.yml */
package:
  name: bcfg

sources:
  - logic/bcfg_pkg.sv
  - logic/bus_cmd_decode.sv
  - logic/boot_config.sv
  - logic/read_response.sv
  - logic/bcfg_top.sv
  - target: test
    files:
      - testbench/bcfg_checker.sv
      - testbench/tb_bcfg_top.sv

/* files.f */
logic/bcfg_pkg.sv
logic/bus_cmd_decode.sv
logic/boot_config.sv
logic/read_response.sv
logic/bcfg_top.sv
testbench/bcfg_checker.sv
testbench/tb_bcfg_top.sv

/* logic/bcfg_pkg.sv */
`default_nettype none

package bcfg_pkg;

    // address space codes, top nibble of the 16-bit address
    localparam logic [3:0] SPACE_GLOB = 4'd0;
    localparam logic [3:0] SPACE_IO   = 4'd1;   // anything else is unmapped

    // global register map
    localparam logic [11:0] REG_STATUS    = 12'd0;
    localparam logic [11:0] REG_TIMESTAMP = 12'd1;
    localparam logic [11:0] REG_SCRATCH   = 12'd2;

    localparam logic [15:0] BCFG_VERSION = 16'h0300;   // status[31:16]

    // connector banks J1 / J2
    localparam int IO1_WIDTH = 34;
    localparam int IO2_WIDTH = 40;
    localparam int IO1_BYTES = 5;   // valid byte indices on IO1
    localparam int IO2_BYTES = 5;   // valid byte indices on IO2

    // read bound applied after the access stage. the narrower bank is
    // zero-extended into the word, so its upper bytes read back as 0
    localparam int IO_BYTES_MAX = (IO1_BYTES > IO2_BYTES) ? IO1_BYTES : IO2_BYTES;

    localparam int ACC_W = IO2_WIDTH;   // access word, widest bank

    // global register view
    typedef struct packed {
        logic [3:0]  space_sel;
        logic [11:0] reg_index;
    } glob_addr_t;

    // connector byte view
    typedef struct packed {
        logic [3:0] space_sel;
        logic [2:0] rsvd_hi;
        logic       conn_sel;      // 0 = IO1, 1 = IO2
        logic [3:0] rsvd_lo;
        logic [3:0] byte_index;
    } io_addr_t;

    typedef union packed {
        glob_addr_t glob;
        io_addr_t   io;
    } reg_addr_u;

    typedef enum logic [1:0] {
        KIND_GLOB,
        KIND_IO,
        KIND_BAD
    } acc_kind_e;

    // host command
    typedef struct packed {
        logic        wr;
        logic [7:0]  tag;     // echoed back
        reg_addr_u   addr;
        logic [31:0] wdata;
    } cmd_t;

    // decoded command, stage 1 out
    typedef struct packed {
        logic        wr;
        logic [7:0]  tag;
        reg_addr_u   addr;
        logic [31:0] wdata;
        acc_kind_e   kind;
    } dec_t;

    // access result, stage 2 out
    typedef struct packed {
        logic [7:0]       tag;
        logic             wr;
        acc_kind_e        kind;
        logic [3:0]       byte_index;
        logic [ACC_W-1:0] word;    // global word or whole pin vector
    } acc_t;

    typedef struct packed {
        logic [7:0]  tag;
        logic        wr;
        logic        err;
        logic [31:0] rdata;
    } rsp_t;

endpackage

`default_nettype wire

/* logic/bcfg_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bcfg_top (
    input  wire logic                           sysclk,
    input  wire logic                           arst_n,
    input  wire logic                           cmd_valid,
    input  bcfg_pkg::cmd_t                      cmd,
    input  wire logic [3:0]                     board_id,
    input  wire logic                           is_v30,
    input  wire logic [bcfg_pkg::IO1_WIDTH-1:0] io1_in,    // J1 pins in
    input  wire logic [bcfg_pkg::IO2_WIDTH-1:0] io2_in,    // J2 pins in
    output logic                                rsp_valid,
    output bcfg_pkg::rsp_t                      rsp,
    output logic [bcfg_pkg::IO1_WIDTH-1:0]      io1_out,
    output logic [bcfg_pkg::IO1_WIDTH-1:0]      io1_oe,   // 1 = drive pin
    output logic [bcfg_pkg::IO2_WIDTH-1:0]      io2_out,
    output logic [bcfg_pkg::IO2_WIDTH-1:0]      io2_oe
);

    import bcfg_pkg::*;

    logic dec_valid;   // stage 1 -> 2
    dec_t dec;
    logic acc_valid;   // stage 2 -> 3
    acc_t acc;

    bus_cmd_decode i_bus_cmd_decode (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    boot_config i_boot_config (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .board_id  (board_id),
        .is_v30    (is_v30),
        .io1_in    (io1_in),
        .io2_in    (io2_in),
        .acc_valid (acc_valid),
        .acc       (acc),
        .io1_out   (io1_out),
        .io1_oe    (io1_oe),
        .io2_out   (io2_out),
        .io2_oe    (io2_oe)
    );

    read_response i_read_response (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .acc_valid (acc_valid),
        .acc       (acc),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

/* logic/boot_config.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_config (
    input  wire logic                         sysclk,
    input  wire logic                         arst_n,
    input  wire logic                         dec_valid,
    input  bcfg_pkg::dec_t                    dec,
    input  wire logic [3:0]                   board_id,   // rotary switch
    input  wire logic                         is_v30,
    input  wire logic [bcfg_pkg::IO1_WIDTH-1:0] io1_in,
    input  wire logic [bcfg_pkg::IO2_WIDTH-1:0] io2_in,
    output logic                              acc_valid,
    output bcfg_pkg::acc_t                    acc,
    output logic [bcfg_pkg::IO1_WIDTH-1:0]    io1_out,
    output logic [bcfg_pkg::IO1_WIDTH-1:0]    io1_oe,
    output logic [bcfg_pkg::IO2_WIDTH-1:0]    io2_out,
    output logic [bcfg_pkg::IO2_WIDTH-1:0]    io2_oe
);

    import bcfg_pkg::*;

    logic [31:0]          timestamp;   // free-running
    logic [31:0]          scratch;
    logic [IO1_WIDTH-1:0] io1_meta, io1_sync;   // 2-flop syncs
    logic [IO2_WIDTH-1:0] io2_meta, io2_sync;

    logic                 wr_en;
    logic                 io1_wr, io2_wr;   // valid byte write per bank
    logic [ACC_W-1:0]     io1_out_nxt, io1_oe_nxt;
    logic [ACC_W-1:0]     io2_out_nxt, io2_oe_nxt;
    logic [ACC_W-1:0]     rd_word;

    // overwrite one byte lane of a bank-wide vector
    function automatic logic [ACC_W-1:0] byte_set(input logic [ACC_W-1:0] cur,
                                                  input logic [3:0]       idx,
                                                  input logic [7:0]       val);
        logic [ACC_W-1:0] res;
        res = cur;
        for (int b = 0; b < ACC_W / 8; b++) begin
            if (idx == 4'(b)) res[8*b +: 8] = val;
        end
        return res;
    endfunction

    assign wr_en  = dec_valid && dec.wr;
    assign io1_wr = wr_en && (dec.kind == KIND_IO) && !dec.addr.io.conn_sel
                    && (dec.addr.io.byte_index < 4'(IO1_BYTES));
    assign io2_wr = wr_en && (dec.kind == KIND_IO) && dec.addr.io.conn_sel
                    && (dec.addr.io.byte_index < 4'(IO2_BYTES));

    // wdata[7:0] -> out byte, wdata[15:8] -> oe byte
    always_comb begin
        io1_out_nxt = byte_set(ACC_W'(io1_out), dec.addr.io.byte_index, dec.wdata[7:0]);
        io1_oe_nxt  = byte_set(ACC_W'(io1_oe), dec.addr.io.byte_index, dec.wdata[15:8]);
        io2_out_nxt = byte_set(io2_out, dec.addr.io.byte_index, dec.wdata[7:0]);
        io2_oe_nxt  = byte_set(io2_oe, dec.addr.io.byte_index, dec.wdata[15:8]);
    end

    // read mux, value as seen at this edge
    always_comb begin
        rd_word = '0;
        if (dec.kind == KIND_GLOB) begin
            case (dec.addr.glob.reg_index)
                REG_STATUS:    rd_word = ACC_W'({BCFG_VERSION, 11'd0, is_v30, board_id});
                REG_TIMESTAMP: rd_word = ACC_W'(timestamp);
                REG_SCRATCH:   rd_word = ACC_W'(scratch);
                default:       rd_word = '0;
            endcase
        end else if (dec.kind == KIND_IO) begin
            rd_word = dec.addr.io.conn_sel ? io2_sync : ACC_W'(io1_sync);   // whole bank
        end
    end

    // pin synchronizers
    always_ff @(posedge sysclk) begin
        io1_meta <= io1_in;
        io1_sync <= io1_meta;
        io2_meta <= io2_in;
        io2_sync <= io2_meta;
    end

    // timestamp, a load wins over the increment
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            timestamp <= '0;
        end else if (wr_en && dec.kind == KIND_GLOB
                     && dec.addr.glob.reg_index == REG_TIMESTAMP) begin
            timestamp <= dec.wdata;
        end else begin
            timestamp <= timestamp + 32'd1;
        end
    end

    // scratch and connector registers, all pins input after reset
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            scratch <= '0;
            io1_out <= '0;
            io1_oe  <= '0;
            io2_out <= '0;
            io2_oe  <= '0;
        end else begin
            if (wr_en && dec.kind == KIND_GLOB && dec.addr.glob.reg_index == REG_SCRATCH)
                scratch <= dec.wdata;
            if (io1_wr) begin
                io1_out <= io1_out_nxt[IO1_WIDTH-1:0];   // upper bits dropped
                io1_oe  <= io1_oe_nxt[IO1_WIDTH-1:0];
            end
            if (io2_wr) begin
                io2_out <= io2_out_nxt;
                io2_oe  <= io2_oe_nxt;
            end
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) acc_valid <= 1'b0;
        else         acc_valid <= dec_valid;
    end

    always_ff @(posedge sysclk) begin
        if (dec_valid) begin
            acc.tag        <= dec.tag;
            acc.wr         <= dec.wr;
            acc.kind       <= dec.kind;
            acc.byte_index <= dec.addr.io.byte_index;
            acc.word       <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* logic/bus_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_cmd_decode (
    input  wire logic           sysclk,
    input  wire logic           arst_n,
    input  wire logic           cmd_valid,   // one-cycle strobe from host link
    input  bcfg_pkg::cmd_t      cmd,
    output logic                dec_valid,
    output bcfg_pkg::dec_t      dec
);

    import bcfg_pkg::*;

    acc_kind_e kind_nxt;
    logic      glob_hit;   // index is one of the mapped globals

    // address check, only place validity is judged
    always_comb begin
        glob_hit = (cmd.addr.glob.reg_index == REG_STATUS)
                || (cmd.addr.glob.reg_index == REG_TIMESTAMP)
                || (cmd.addr.glob.reg_index == REG_SCRATCH);

        if (cmd.addr.glob.space_sel == SPACE_GLOB) begin
            kind_nxt = glob_hit ? KIND_GLOB : KIND_BAD;
        end else if (cmd.addr.glob.space_sel == SPACE_IO) begin
            kind_nxt = KIND_IO;   // byte range handled downstream
        end else begin
            kind_nxt = KIND_BAD;
        end
    end

    // strobe
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= cmd_valid;
        end
    end

    // payload, only loaded on a strobe
    always_ff @(posedge sysclk) begin
        if (cmd_valid) begin
            dec.wr    <= cmd.wr;
            dec.tag   <= cmd.tag;
            dec.addr  <= cmd.addr;
            dec.wdata <= cmd.wdata;
            dec.kind  <= kind_nxt;
        end
    end

endmodule

`default_nettype wire

/* logic/read_response.sv */
`timescale 1ns/1ps
`default_nettype none

module read_response (
    input  wire logic      sysclk,
    input  wire logic      arst_n,
    input  wire logic      acc_valid,
    input  bcfg_pkg::acc_t acc,
    output logic           rsp_valid,   // one-cycle strobe to host link
    output bcfg_pkg::rsp_t rsp
);

    import bcfg_pkg::*;

    logic [7:0]  io_byte;
    logic [31:0] rdata_nxt;

    // byte pick, indices past the bound fall through to 0
    always_comb begin
        io_byte = 8'd0;
        for (int b = 0; b < IO_BYTES_MAX; b++) begin
            if (acc.byte_index == 4'(b)) io_byte = acc.word[8*b +: 8];
        end
    end

    always_comb begin
        if (acc.wr) begin
            rdata_nxt = 32'd0;   // writes never return data
        end else begin
            case (acc.kind)
                KIND_GLOB: rdata_nxt = acc.word[31:0];
                KIND_IO:   rdata_nxt = {24'd0, io_byte};
                default:   rdata_nxt = 32'd0;   // unmapped
            endcase
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= acc_valid;
        end
    end

    always_ff @(posedge sysclk) begin
        if (acc_valid) begin
            rsp.tag   <= acc.tag;
            rsp.wr    <= acc.wr;
            rsp.err   <= (acc.kind == KIND_BAD);
            rsp.rdata <= rdata_nxt;
        end
    end

endmodule

`default_nettype wire

/* testbench/bcfg_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module bcfg_checker (
    input  wire logic                                                   sysclk,
    input  wire logic                                                   cmd_valid,
    input  wire bcfg_pkg::rsp_t                                         exp_rsp,
    input  wire logic [2*bcfg_pkg::IO1_WIDTH+2*bcfg_pkg::IO2_WIDTH-1:0] exp_io,
    input  wire logic [3:0]                                             test_id,
    input  wire logic                                                   rsp_valid,
    input  wire bcfg_pkg::rsp_t                                         rsp,
    input  wire logic [2*bcfg_pkg::IO1_WIDTH+2*bcfg_pkg::IO2_WIDTH-1:0] dut_io,
    output int                                                          mismatch_cnt,
    output int                                                          timing_cnt,
    output int                                                          pending_cnt
);

    import bcfg_pkg::*;

    // one entry per command, filled on the sampling edge
    typedef struct packed {
        rsp_t                               rsp;
        logic [31:0]                        cyc;   // edge the command was sampled on
        logic [3:0]                         tid;
        logic [2*IO1_WIDTH+2*IO2_WIDTH-1:0] io;    // out/oe after this command
    } pend_t;

    pend_t       rsp_q[$];
    pend_t       io_q[$];
    pend_t       head;
    logic [31:0] cyc = '0;
    int          mism = 0;
    int          late = 0;
    int          pend = 0;

    assign mismatch_cnt = mism;
    assign timing_cnt   = late;
    assign pending_cnt  = pend;

    function automatic string test_label(input logic [3:0] id);
        case (id)
            4'd1:    return "reset_status";
            4'd2:    return "scratch_rw";
            4'd3:    return "timestamp";
            4'd4:    return "io_bytes";
            4'd5:    return "unmapped";
            default: return "random_burst";
        endcase
    endfunction

    // inputs settle on the falling edge, outputs are read before this edge updates them
    always @(posedge sysclk) begin
        cyc = cyc + 1;
        if (rsp_valid === 1'b1) begin
            if (rsp_q.size() == 0) begin
                $display("Error: response tag %02h came with no command outstanding", rsp.tag);
                late++;
            end else begin
                head = rsp_q.pop_front();
                if (cyc != head.cyc + 3) begin
                    $display("Error: response tag %02h came %0d cycles after its command, not 3",
                             rsp.tag, cyc - head.cyc);
                    late++;
                end
                if (rsp !== head.rsp) begin
                    $display("Mismatch %s: expected rsp %h, actual rsp %h",
                             test_label(head.tid), head.rsp, rsp);
                    mism++;
                end
            end
        end else if (rsp_q.size() > 0 && cyc >= rsp_q[0].cyc + 3) begin
            head = rsp_q.pop_front();   // overdue
            $display("Error: no response 3 cycles after command tag %02h", head.rsp.tag);
            late++;
        end
        // state after the stage 2 edge of the command, before the next one lands
        if (io_q.size() > 0 && cyc == io_q[0].cyc + 2) begin
            head = io_q.pop_front();
            if (dut_io !== head.io) begin
                $display("Mismatch %s: expected out/oe %h, actual out/oe %h",
                         test_label(head.tid), head.io, dut_io);
                mism++;
            end
        end
        if (cmd_valid === 1'b1) begin
            head.rsp = exp_rsp;
            head.cyc = cyc;
            head.tid = test_id;
            head.io  = exp_io;
            rsp_q.push_back(head);
            io_q.push_back(head);
        end
        pend = rsp_q.size();
    end

endmodule

`default_nettype wire

/* testbench/tb_bcfg_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bcfg_top;

    import bcfg_pkg::*;

    logic                 sysclk;
    logic                 arst_n;
    logic                 cmd_valid;
    cmd_t                 cmd;
    logic [3:0]           board_id;
    logic                 is_v30;
    logic [IO1_WIDTH-1:0] io1_in;
    logic [IO2_WIDTH-1:0] io2_in;
    logic                 rsp_valid;
    rsp_t                 rsp;
    logic [IO1_WIDTH-1:0] io1_out, io1_oe;
    logic [IO2_WIDTH-1:0] io2_out, io2_oe;

    rsp_t                               exp_rsp;   // handed to the checker with each command
    logic [2*IO1_WIDTH+2*IO2_WIDTH-1:0] exp_io;
    logic [3:0]                         test_id;
    int                                 mismatch_cnt, timing_cnt, pending_cnt;

    // reference model state
    logic [31:0]          scratch_m;
    logic [IO1_WIDTH-1:0] io1_out_m, io1_oe_m;
    logic [IO2_WIDTH-1:0] io2_out_m, io2_oe_m;
    logic [31:0]          ts_base;        // counter value seen one edge after ts_edge
    int unsigned          ts_edge;
    int unsigned          cyc = 0;        // rising edges so far
    logic [31:0]          rng = 32'h4faa_6032;
    logic [7:0]           tag_cnt;
    int                   scratch_pairs = 32;
    int                   ts_rounds     = 8;
    int                   burst_len     = 200;
    int                   watch_cycles;

    bcfg_top i_bcfg_top (.*);

    bcfg_checker i_bcfg_checker (
        .sysclk(sysclk), .cmd_valid(cmd_valid), .exp_rsp(exp_rsp), .exp_io(exp_io),
        .test_id(test_id), .rsp_valid(rsp_valid), .rsp(rsp),
        .dut_io({io1_out, io1_oe, io2_out, io2_oe}),
        .mismatch_cnt(mismatch_cnt), .timing_cnt(timing_cnt), .pending_cnt(pending_cnt)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;   // 4 ns
    end

    always @(posedge sysclk) cyc <= cyc + 1;

    function automatic logic [31:0] rand32();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // byte idx of a width-bit bank with 0 past the bound or the top pin
    function automatic logic [7:0] pick_byte(input logic [IO2_WIDTH-1:0] v, input int width,
                                             input int nbytes, input logic [3:0] idx);
        logic [7:0] res;
        res = '0;
        for (int i = 0; i < 8; i++) begin
            if (int'(idx) < nbytes && 8 * int'(idx) + i < width) res[i] = v[8 * int'(idx) + i];
        end
        return res;
    endfunction

    function automatic logic [IO2_WIDTH-1:0] put_byte(input logic [IO2_WIDTH-1:0] v,
                                                      input int width, input int nbytes,
                                                      input logic [3:0] idx, input logic [7:0] val);
        for (int i = 0; i < 8; i++) begin
            if (int'(idx) < nbytes && 8 * int'(idx) + i < width) v[8 * int'(idx) + i] = val[i];
        end
        return v;
    endfunction

    // expected response from the register map rules
    function automatic rsp_t ref_rsp(input cmd_t c, input int unsigned acc_edge);
        rsp_t        r;
        logic [15:0] a;
        logic [7:0]  pin;
        a       = c.addr;
        r.tag   = c.tag;
        r.wr    = c.wr;
        r.err   = 1'b0;
        r.rdata = '0;
        pin = a[8] ? pick_byte(io2_in, IO2_WIDTH, IO2_BYTES, a[3:0])
                   : pick_byte(IO2_WIDTH'(io1_in), IO1_WIDTH, IO1_BYTES, a[3:0]);
        if (a[15:12] == SPACE_GLOB
            && (a[11:0] == REG_STATUS || a[11:0] == REG_TIMESTAMP || a[11:0] == REG_SCRATCH)) begin
            if (!c.wr && a[11:0] == REG_STATUS)    r.rdata = {BCFG_VERSION, 11'd0, is_v30, board_id};
            if (!c.wr && a[11:0] == REG_TIMESTAMP) r.rdata = ts_base + (acc_edge - ts_edge - 1);
            if (!c.wr && a[11:0] == REG_SCRATCH)   r.rdata = scratch_m;
        end else if (a[15:12] == SPACE_IO) begin
            if (!c.wr) r.rdata = {24'd0, pin};
        end else begin
            r.err = 1'b1;   // unmapped
        end
        return r;
    endfunction

    task automatic model_write(input cmd_t c);
        logic [15:0] a;
        a = c.addr;
        if (c.wr && a[15:12] == SPACE_GLOB && a[11:0] == REG_TIMESTAMP) begin
            ts_base = c.wdata;
            ts_edge = cyc + 2;   // loaded on the stage 2 edge
        end
        if (c.wr && a[15:12] == SPACE_GLOB && a[11:0] == REG_SCRATCH) scratch_m = c.wdata;
        if (c.wr && a[15:12] == SPACE_IO && !a[8]) begin
            io1_out_m = IO1_WIDTH'(put_byte(IO2_WIDTH'(io1_out_m), IO1_WIDTH, IO1_BYTES,
                                            a[3:0], c.wdata[7:0]));
            io1_oe_m  = IO1_WIDTH'(put_byte(IO2_WIDTH'(io1_oe_m), IO1_WIDTH, IO1_BYTES,
                                            a[3:0], c.wdata[15:8]));
        end
        if (c.wr && a[15:12] == SPACE_IO && a[8]) begin
            io2_out_m = put_byte(io2_out_m, IO2_WIDTH, IO2_BYTES, a[3:0], c.wdata[7:0]);
            io2_oe_m  = put_byte(io2_oe_m, IO2_WIDTH, IO2_BYTES, a[3:0], c.wdata[15:8]);
        end
    endtask

    // one command driven on the next falling edge and sampled on the rising edge after it
    task automatic send(input logic wr, input logic [15:0] addr, input logic [31:0] wdata);
        cmd_t c;
        @(negedge sysclk);
        c.wr    = wr;
        c.tag   = tag_cnt;
        c.addr  = addr;
        c.wdata = wdata;
        tag_cnt = tag_cnt + 1;
        exp_rsp = ref_rsp(c, cyc + 2);
        model_write(c);
        exp_io    = {io1_out_m, io1_oe_m, io2_out_m, io2_oe_m};
        cmd       = c;
        cmd_valid = 1'b1;
    endtask

    task automatic idle(input int n);
        @(negedge sysclk);
        cmd_valid = 1'b0;
        repeat (n - 1) @(negedge sysclk);
    endtask

    function automatic logic [15:0] io_addr(input logic conn, input logic [3:0] idx);
        return {SPACE_IO, 3'd0, conn, 4'd0, idx};
    endfunction

    function automatic logic [15:0] rand_addr(input logic [31:0] r);
        case (r[1:0])
            2'd0:    return {SPACE_GLOB, 10'd0, r[3:2]};                      // index 3 unmapped
            2'd1:    return {SPACE_IO, r[6:4], r[7], r[11:8], 1'b0, r[14:12]}; // junk rsvd bits
            2'd2:    return io_addr(r[7], {1'b0, r[14:12]});
            default: return r[31:16];
        endcase
    endfunction

    initial begin
        // commands, reset, idle gaps and slack
        watch_cycles = 16 + 2 + 2 * scratch_pairs + 10 * ts_rounds + 30 + 19 + burst_len + 200;
        #(watch_cycles * 4);
        $display("Error: watchdog expired after %0d cycles, the run did not finish", watch_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] r;
        arst_n    = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        board_id  = 4'h9;
        is_v30    = 1'b1;
        io1_in    = '0;
        io2_in    = '0;
        exp_rsp   = '0;
        exp_io    = '0;
        test_id   = 4'd1;
        tag_cnt   = '0;
        scratch_m = '0;
        io1_out_m = '0;
        io1_oe_m  = '0;
        io2_out_m = '0;
        io2_oe_m  = '0;
        repeat (16) @(posedge sysclk);
        @(negedge sysclk);
        arst_n  = 1'b1;
        ts_base = '0;
        ts_edge = cyc;   // counts up from 0 after the next edge

        // status and idle outputs after reset
        send(1'b0, {SPACE_GLOB, REG_STATUS}, 32'd0);
        idle(4);
        board_id = 4'h6;
        is_v30   = 1'b0;
        send(1'b0, {SPACE_GLOB, REG_STATUS}, 32'd0);
        idle(4);

        test_id = 4'd2;   // write then read on the next cycle
        repeat (scratch_pairs) begin
            send(1'b1, {SPACE_GLOB, REG_SCRATCH}, rand32());
            send(1'b0, {SPACE_GLOB, REG_SCRATCH}, rand32());
        end
        idle(4);

        test_id = 4'd3;
        repeat (ts_rounds) begin
            send(1'b1, {SPACE_GLOB, REG_TIMESTAMP}, rand32());
            send(1'b0, {SPACE_GLOB, REG_TIMESTAMP}, 32'd0);   // right after the load
            r = rand32() % 8;
            if (r != 0) idle(int'(r));
            send(1'b0, {SPACE_GLOB, REG_TIMESTAMP}, 32'd0);
        end
        idle(4);

        test_id = 4'd4;   // bytes 5 and 6 are past the bound
        for (int conn = 0; conn < 2; conn++) begin
            for (int b = 0; b < 7; b++) send(1'b1, io_addr(conn[0], 4'(b)), rand32());
        end
        idle(2);
        io1_in = IO1_WIDTH'({rand32(), rand32()});
        io2_in = IO2_WIDTH'({rand32(), rand32()});
        idle(3);   // through the synchronizer
        for (int conn = 0; conn < 2; conn++) begin
            for (int b = 0; b < 8; b++) send(1'b0, io_addr(conn[0], 4'(b)), 32'd0);
        end
        idle(4);

        test_id = 4'd5;
        repeat (8) begin
            r = rand32();
            send(r[0], {SPACE_GLOB, 12'd3 + 12'(r[15:4] % 12'd4093)}, rand32());
            r = rand32();
            send(r[0], {4'd2 + 4'(r[7:4] % 4'd14), r[19:8]}, rand32());
        end
        send(1'b0, {SPACE_GLOB, REG_SCRATCH}, 32'd0);
        send(1'b0, {SPACE_GLOB, REG_STATUS}, 32'd0);
        send(1'b0, {SPACE_GLOB, REG_TIMESTAMP}, 32'd0);   // counter not disturbed
        idle(4);

        test_id = 4'd6;
        io1_in = IO1_WIDTH'({rand32(), rand32()});
        io2_in = IO2_WIDTH'({rand32(), rand32()});
        idle(3);
        repeat (burst_len) begin
            r = rand32();
            send(r[31], rand_addr(rand32()), rand32());
        end
        idle(8);   // drain

        $display("checks done: %0d mismatches, %0d timing errors, %0d responses missing",
                 mismatch_cnt, timing_cnt, pending_cnt);
        if (mismatch_cnt + timing_cnt + pending_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
